// ==== logic/lb_pkg.sv ====
// local bus definitions
// widths of the external and internal config bus, block codes of the
// three configuration banks and the word returned for unmapped blocks
`default_nettype none

package lb_pkg;

    //************************************************************************
    // bus widths
    //************************************************************************
    localparam int LB_ADDR_W = 32;
    localparam int LB_DATA_W = 32;

    // address split, block field above the word offset
    localparam int LB_BLK_W = 3;
    localparam int LB_OFF_W = 13;

    //************************************************************************
    // block codes
    //************************************************************************
    // match engine config
    localparam logic [LB_BLK_W-1:0] BLK_GME = 3'd3;
    // action config
    localparam logic [LB_BLK_W-1:0] BLK_GAC = 3'd4;
    // output engine config
    localparam logic [LB_BLK_W-1:0] BLK_GOE = 3'd5;

    // read value for a block code with no bank behind it
    localparam logic [LB_DATA_W-1:0] UNMAPPED_RDATA = 32'hdead_beef;

    // one address word, seen whole or split into block and offset
    typedef union packed {
        logic [LB_ADDR_W-1:0] raw;
        struct packed {
            logic [LB_ADDR_W-LB_BLK_W-LB_OFF_W-1:0] rsvd;
            logic [LB_BLK_W-1:0]                    blk;
            logic [LB_OFF_W-1:0]                    off;
        } fld;
    } lb_addr_u;

endpackage

`default_nettype wire

// ==== logic/regmap_pkg.sv ====
// configuration register map
// word counts and identification words of the match-engine, action
// and output-engine banks, and where the identification word sits
`default_nettype none

package regmap_pkg;

    //************************************************************************
    // bank depths in 32-bit words
    //************************************************************************
    // id word included in the count
    localparam int GME_DEPTH = 16;
    localparam int GAC_DEPTH = 32;
    localparam int GOE_DEPTH = 8;

    //************************************************************************
    // identification words
    //************************************************************************
    // ascii block tag in the upper bytes, revision in the low byte
    localparam logic [31:0] GME_ID = 32'h474d_4501;
    localparam logic [31:0] GAC_ID = 32'h4741_4301;
    localparam logic [31:0] GOE_ID = 32'h474f_4501;

    // read-only id word offset, same in every bank
    localparam int ID_OFFSET = 0;

endpackage

`default_nettype wire

// ==== logic/cfg_dispatch.sv ====
// config access dispatcher
// synchronizes the local-bus chip select, captures one access, decodes
// the block field and forwards the access to one of three register
// banks; returns read data and holds the acknowledge until the master
// releases the select
`timescale 1ns/100ps
`default_nettype none

module cfg_dispatch (
    input  logic                        clk,
    input  logic                        rst_n,
    // external local bus
    input  logic                        ctrl2um_cs_n,
    input  logic                        ctrl_cmd,
    input  lb_pkg::lb_addr_u            ctrl_addr,
    input  logic [lb_pkg::LB_DATA_W-1:0] ctrl_datain,
    output logic                        um2ctrl_ack_n,
    output logic [lb_pkg::LB_DATA_W-1:0] ctrl_dataout,
    // bank selects
    output logic                        gme_cs_n,
    output logic                        gac_cs_n,
    output logic                        goe_cs_n,
    // shared config bus
    output logic                        cfg_rw,
    output lb_pkg::lb_addr_u            cfg_addr,
    output logic [lb_pkg::LB_DATA_W-1:0] cfg_wdata,
    // bank responses
    input  logic                        gme_ack_n,
    input  logic                        gac_ack_n,
    input  logic                        goe_ack_n,
    input  logic [lb_pkg::LB_DATA_W-1:0] gme_rdata,
    input  logic [lb_pkg::LB_DATA_W-1:0] gac_rdata,
    input  logic [lb_pkg::LB_DATA_W-1:0] goe_rdata
);

    // access states
    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_DECODE   = 2'd1;
    localparam logic [1:0] ST_WAIT_ACK = 2'd2;
    localparam logic [1:0] ST_RELEASE  = 2'd3;

    logic [1:0]                  state;
    logic                        cs_meta;
    logic                        cs_sync;
    logic                        start;
    logic                        sel_ack_n;
    logic [lb_pkg::LB_DATA_W-1:0] sel_rdata;

    //************************************************************************
    // chip select synchronizer
    //************************************************************************
    // async select through two flops to an active-high level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_meta <= 1'b0;
            cs_sync <= 1'b0;
        end else begin
            cs_meta <= ~ctrl2um_cs_n;
            cs_sync <= cs_meta;
        end
    end

    assign start = (state == ST_IDLE) && cs_sync;

    //************************************************************************
    // response select
    //************************************************************************
    // follow the bank whose select is low
    always_comb begin
        case ({gme_cs_n, gac_cs_n, goe_cs_n})
            3'b011: begin
                sel_ack_n = gme_ack_n;
                sel_rdata = gme_rdata;
            end
            3'b101: begin
                sel_ack_n = gac_ack_n;
                sel_rdata = gac_rdata;
            end
            3'b110: begin
                sel_ack_n = goe_ack_n;
                sel_rdata = goe_rdata;
            end
            default: begin
                sel_ack_n = 1'b1;
                sel_rdata = '0;
            end
        endcase
    end

    // capture the command while the pins are steady under the select
    always_ff @(posedge clk) begin
        if (start) begin
            cfg_rw        <= ctrl_cmd;
            cfg_addr.raw  <= ctrl_addr.raw;
            cfg_wdata     <= ctrl_datain;
        end
    end

    //************************************************************************
    // access state machine
    //************************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            um2ctrl_ack_n <= 1'b1;
            ctrl_dataout  <= '0;
            gme_cs_n      <= 1'b1;
            gac_cs_n      <= 1'b1;
            goe_cs_n      <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    um2ctrl_ack_n <= 1'b1;
                    if (start) begin
                        state <= ST_DECODE;
                    end
                end

                // decode the block field of the captured word
                ST_DECODE: begin
                    case (cfg_addr.fld.blk)
                        lb_pkg::BLK_GME: begin
                            gme_cs_n <= 1'b0;
                            state    <= ST_WAIT_ACK;
                        end
                        lb_pkg::BLK_GAC: begin
                            gac_cs_n <= 1'b0;
                            state    <= ST_WAIT_ACK;
                        end
                        lb_pkg::BLK_GOE: begin
                            goe_cs_n <= 1'b0;
                            state    <= ST_WAIT_ACK;
                        end
                        default: begin
                            // no bank behind this code so answer at once
                            if (cfg_rw) begin
                                ctrl_dataout <= lb_pkg::UNMAPPED_RDATA;
                            end
                            state <= ST_RELEASE;
                        end
                    endcase
                end

                ST_WAIT_ACK: begin
                    if (!sel_ack_n) begin
                        gme_cs_n <= 1'b1;
                        gac_cs_n <= 1'b1;
                        goe_cs_n <= 1'b1;
                        // writes keep the last read value
                        if (cfg_rw) begin
                            ctrl_dataout <= sel_rdata;
                        end
                        state <= ST_RELEASE;
                    end
                end

                // hold ack until the master lets go of the select
                ST_RELEASE: begin
                    if (cs_sync) begin
                        um2ctrl_ack_n <= 1'b0;
                    end else begin
                        um2ctrl_ack_n <= 1'b1;
                        state         <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/cfg_reg_bank.sv ====
// configuration register bank
// REG_DEPTH words of 32 bits on the shared config bus; offset zero
// reads back the bank id and ignores writes, offsets past the depth
// read zero; one-cycle registered acknowledge, active low
`timescale 1ns/100ps
`default_nettype none

module cfg_reg_bank #(
    parameter int                        REG_DEPTH = 16,
    parameter logic [lb_pkg::LB_DATA_W-1:0] BANK_ID   = '0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cs_n,
    input  logic                        cfg_rw,
    input  lb_pkg::lb_addr_u            cfg_addr,
    input  logic [lb_pkg::LB_DATA_W-1:0] cfg_wdata,
    output logic                        ack_n,
    output logic [lb_pkg::LB_DATA_W-1:0] rdata
);

    // word index width
    localparam int IDX_W = (REG_DEPTH > 1) ? $clog2(REG_DEPTH) : 1;

    logic [lb_pkg::LB_DATA_W-1:0] regs [REG_DEPTH];
    logic                        access;
    logic                        in_range;
    logic                        is_id;
    logic [IDX_W-1:0]            idx;

    //************************************************************************
    // offset decode
    //************************************************************************
    // one access per select, first edge with select low
    assign access   = ~cs_n & ack_n;
    assign in_range = cfg_addr.fld.off < lb_pkg::LB_OFF_W'(REG_DEPTH);
    assign is_id    = cfg_addr.fld.off == lb_pkg::LB_OFF_W'(regmap_pkg::ID_OFFSET);
    assign idx      = cfg_addr.fld.off[IDX_W-1:0];

    //************************************************************************
    // ack and register write
    //************************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_n <= 1'b1;
            for (int i = 0; i < REG_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (access) begin
                ack_n <= 1'b0;
                // id word and out of range are dropped
                if (!cfg_rw && in_range && !is_id) begin
                    regs[idx] <= cfg_wdata;
                end
            end else if (cs_n) begin
                // release one cycle after the select rises
                ack_n <= 1'b1;
            end
        end
    end

    // read data, registered with the ack
    always_ff @(posedge clk) begin
        if (access && cfg_rw) begin
            if (is_id) begin
                rdata <= BANK_ID;
            end else if (in_range) begin
                rdata <= regs[idx];
            end else begin
                rdata <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/um_cfg_top.sv ====
// user module config side
// local-bus dispatcher in front of the match-engine, action and
// output-engine register banks on one shared config bus
`timescale 1ns/100ps
`default_nettype none

module um_cfg_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ctrl2um_cs_n,
    input  logic                        ctrl_cmd,
    input  lb_pkg::lb_addr_u            ctrl_addr,
    input  logic [lb_pkg::LB_DATA_W-1:0] ctrl_datain,
    output logic                        um2ctrl_ack_n,
    output logic [lb_pkg::LB_DATA_W-1:0] ctrl_dataout
);

    // shared config bus
    logic                        cfg_rw;
    lb_pkg::lb_addr_u            cfg_addr;
    logic [lb_pkg::LB_DATA_W-1:0] cfg_wdata;

    // per bank handshake
    logic                        gme_cs_n;
    logic                        gac_cs_n;
    logic                        goe_cs_n;
    logic                        gme_ack_n;
    logic                        gac_ack_n;
    logic                        goe_ack_n;
    logic [lb_pkg::LB_DATA_W-1:0] gme_rdata;
    logic [lb_pkg::LB_DATA_W-1:0] gac_rdata;
    logic [lb_pkg::LB_DATA_W-1:0] goe_rdata;

    //************************************************************************
    // dispatcher
    //************************************************************************
    cfg_dispatch dispatch (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctrl2um_cs_n  (ctrl2um_cs_n),
        .ctrl_cmd      (ctrl_cmd),
        .ctrl_addr     (ctrl_addr),
        .ctrl_datain   (ctrl_datain),
        .um2ctrl_ack_n (um2ctrl_ack_n),
        .ctrl_dataout  (ctrl_dataout),
        .gme_cs_n      (gme_cs_n),
        .gac_cs_n      (gac_cs_n),
        .goe_cs_n      (goe_cs_n),
        .cfg_rw        (cfg_rw),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .gme_ack_n     (gme_ack_n),
        .gac_ack_n     (gac_ack_n),
        .goe_ack_n     (goe_ack_n),
        .gme_rdata     (gme_rdata),
        .gac_rdata     (gac_rdata),
        .goe_rdata     (goe_rdata)
    );

    //************************************************************************
    // register banks
    //************************************************************************
    // match engine, block 3
    cfg_reg_bank #(
        .REG_DEPTH (regmap_pkg::GME_DEPTH),
        .BANK_ID   (regmap_pkg::GME_ID)
    ) bank_gme (
        .clk       (clk),
        .rst_n     (rst_n),
        .cs_n      (gme_cs_n),
        .cfg_rw    (cfg_rw),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .ack_n     (gme_ack_n),
        .rdata     (gme_rdata)
    );

    // action, block 4
    cfg_reg_bank #(
        .REG_DEPTH (regmap_pkg::GAC_DEPTH),
        .BANK_ID   (regmap_pkg::GAC_ID)
    ) bank_gac (
        .clk       (clk),
        .rst_n     (rst_n),
        .cs_n      (gac_cs_n),
        .cfg_rw    (cfg_rw),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .ack_n     (gac_ack_n),
        .rdata     (gac_rdata)
    );

    // output engine, block 5
    cfg_reg_bank #(
        .REG_DEPTH (regmap_pkg::GOE_DEPTH),
        .BANK_ID   (regmap_pkg::GOE_ID)
    ) bank_goe (
        .clk       (clk),
        .rst_n     (rst_n),
        .cs_n      (goe_cs_n),
        .cfg_rw    (cfg_rw),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .ack_n     (goe_ack_n),
        .rdata     (goe_rdata)
    );

endmodule

`default_nettype wire

// ==== include/tb_checks.svh ====
// testbench compare helpers
// error counters and compare tasks for data words and acknowledge
// levels; a mismatch prints FAIL with expected and actual values
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// separate counts for data and handshake errors
int err_data = 0;
int err_ack  = 0;

// 32-bit word compare
task automatic check_data(
    input string                        name,
    input logic [lb_pkg::LB_DATA_W-1:0] exp,
    input logic [lb_pkg::LB_DATA_W-1:0] act
);
    if (act !== exp) begin
        $display("FAIL: %s expected %h actual %h", name, exp, act);
        err_data++;
    end
endtask

// acknowledge level compare
task automatic check_ack(
    input string name,
    input logic  exp,
    input logic  act
);
    if (act !== exp) begin
        $display("FAIL: %s expected %h actual %h", name, exp, act);
        err_ack++;
    end
endtask

`endif

// ==== sim/tb_um_cfg.sv ====
// config side testbench
// drives the local bus of the user-module config top through directed
// tests: reset state, write and read back, id words, out-of-range and
// unmapped blocks, bank isolation and a slow select release
`timescale 1ns/100ps
`default_nettype none

module tb_um_cfg;

    localparam int CLK_PERIOD = 10;
    // bound on each handshake edge, in cycles
    localparam int ACK_WAIT   = 40;
    // transactions issued by all tests together
    localparam int NUM_XFERS  = 67;

    logic                         clk;
    logic                         rst_n;
    logic                         cs_n;
    logic                         cmd;
    lb_pkg::lb_addr_u             addr;
    logic [lb_pkg::LB_DATA_W-1:0] datain;
    logic                         ack_n;
    logic [lb_pkg::LB_DATA_W-1:0] dataout;

    // expected bank contents, index 0 gme, 1 gac, 2 goe
    logic [lb_pkg::LB_DATA_W-1:0] model [3][32];
    int                           err_timeout = 0;
    integer                       seed = 32'hc1ab;

    `include "tb_checks.svh"

    um_cfg_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctrl2um_cs_n  (cs_n),
        .ctrl_cmd      (cmd),
        .ctrl_addr     (addr),
        .ctrl_datain   (datain),
        .um2ctrl_ack_n (ack_n),
        .ctrl_dataout  (dataout)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    //************************************************************************
    // bank lookup and expected values
    //************************************************************************
    function automatic logic [lb_pkg::LB_BLK_W-1:0] bank_blk(input int b);
        case (b)
            0: return lb_pkg::BLK_GME;
            1: return lb_pkg::BLK_GAC;
            default: return lb_pkg::BLK_GOE;
        endcase
    endfunction

    function automatic int bank_depth(input int b);
        case (b)
            0: return regmap_pkg::GME_DEPTH;
            1: return regmap_pkg::GAC_DEPTH;
            default: return regmap_pkg::GOE_DEPTH;
        endcase
    endfunction

    function automatic logic [lb_pkg::LB_DATA_W-1:0] bank_id(input int b);
        case (b)
            0: return regmap_pkg::GME_ID;
            1: return regmap_pkg::GAC_ID;
            default: return regmap_pkg::GOE_ID;
        endcase
    endfunction

    // id word first, then out of range, then stored data
    function automatic logic [lb_pkg::LB_DATA_W-1:0] expect_read(input int b, input int off);
        if (off == regmap_pkg::ID_OFFSET) begin
            return bank_id(b);
        end
        if (off >= bank_depth(b)) begin
            return '0;
        end
        return model[b][off];
    endfunction

    //************************************************************************
    // one local-bus transaction
    //************************************************************************
    task automatic lb_access(
        input  logic                         is_read,
        input  logic [lb_pkg::LB_BLK_W-1:0]  blk,
        input  int                           off,
        input  logic [lb_pkg::LB_DATA_W-1:0] wdata,
        input  int                           hold,
        output logic [lb_pkg::LB_DATA_W-1:0] rdata
    );
        lb_pkg::lb_addr_u a;
        int               cnt;
        a.raw = {16'h0000, blk, lb_pkg::LB_OFF_W'(off)};
        @(negedge clk);
        cmd    = is_read;
        addr   = a;
        datain = wdata;
        cs_n   = 1'b0;
        // wait for the acknowledge
        cnt = 0;
        while (ack_n !== 1'b0 && cnt < ACK_WAIT) begin
            @(negedge clk);
            cnt++;
        end
        if (ack_n !== 1'b0) begin
            $display("acknowledge did not fall within %0d cycles of select", ACK_WAIT);
            err_timeout++;
        end
        rdata = dataout;
        // slow master, ack must stay low meanwhile
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_ack("um2ctrl_ack_n during hold", 1'b0, ack_n);
        end
        cs_n = 1'b1;
        cnt = 0;
        while (ack_n !== 1'b1 && cnt < ACK_WAIT) begin
            @(negedge clk);
            cnt++;
        end
        if (ack_n !== 1'b1) begin
            $display("acknowledge did not rise within %0d cycles of release", ACK_WAIT);
            err_timeout++;
        end
    endtask

    // write through the bus and track what the bank should keep
    task automatic write_word(input int b, input int off, input logic [31:0] data);
        logic [lb_pkg::LB_DATA_W-1:0] rd;
        lb_access(1'b0, bank_blk(b), off, data, 0, rd);
        if (off != regmap_pkg::ID_OFFSET && off < bank_depth(b)) begin
            model[b][off] = data;
        end
    endtask

    task automatic read_check(input int b, input int off, input int hold);
        logic [lb_pkg::LB_DATA_W-1:0] rd;
        lb_access(1'b1, bank_blk(b), off, '0, hold, rd);
        check_data($sformatf("ctrl_dataout bank%0d off%0d", b, off), expect_read(b, off), rd);
    endtask

    //************************************************************************
    // directed tests
    //************************************************************************
    task automatic test_reset_state();
        check_ack("um2ctrl_ack_n after reset", 1'b1, ack_n);
        check_data("ctrl_dataout after reset", '0, dataout);
    endtask

    // first, middle and last data word of each bank
    task automatic test_write_read();
        int offs [3];
        for (int b = 0; b < 3; b++) begin
            offs[0] = 1;
            offs[1] = bank_depth(b) / 2;
            offs[2] = bank_depth(b) - 1;
            for (int k = 0; k < 3; k++) begin
                write_word(b, offs[k], {8'ha5, 8'(b), 8'h3c, 8'(offs[k])});
                read_check(b, offs[k], 0);
            end
        end
    endtask

    task automatic test_id_word();
        for (int b = 0; b < 3; b++) begin
            read_check(b, regmap_pkg::ID_OFFSET, 0);
            write_word(b, regmap_pkg::ID_OFFSET, ~bank_id(b));
            read_check(b, regmap_pkg::ID_OFFSET, 0);
        end
    endtask

    task automatic test_range_unmapped();
        logic [lb_pkg::LB_DATA_W-1:0] rd;
        logic [lb_pkg::LB_BLK_W-1:0]  blks [3];
        // depth+1 aliases word 1 in the low index bits
        for (int b = 0; b < 3; b++) begin
            write_word(b, bank_depth(b) + 1, 32'h0bad_0bad);
            read_check(b, bank_depth(b) + 1, 0);
            read_check(b, 1, 0);
        end
        blks[0] = 3'd0;
        blks[1] = 3'd2;
        blks[2] = 3'd7;
        for (int k = 0; k < 3; k++) begin
            lb_access(1'b1, blks[k], 4, '0, 0, rd);
            check_data($sformatf("ctrl_dataout unmapped blk%0d", blks[k]),
                       lb_pkg::UNMAPPED_RDATA, rd);
        end
        // unmapped write keeps the last read value
        lb_access(1'b0, 3'd1, 4, 32'h1234_5678, 0, rd);
        check_data("ctrl_dataout after unmapped write", lb_pkg::UNMAPPED_RDATA, rd);
    endtask

    // same offset in every bank, different random words
    task automatic test_isolation();
        for (int r = 0; r < 4; r++) begin
            for (int b = 0; b < 3; b++) begin
                write_word(b, 2 + r, $random(seed));
            end
            for (int b = 0; b < 3; b++) begin
                read_check(b, 2 + r, 0);
            end
        end
    endtask

    task automatic test_slow_release();
        write_word(1, 5, $random(seed));
        read_check(1, 5, 20);
        check_ack("um2ctrl_ack_n after release", 1'b1, ack_n);
        read_check(0, 1, 0);
    endtask

    //************************************************************************
    // watchdog
    //************************************************************************
    initial begin
        repeat (NUM_XFERS * 100) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", NUM_XFERS * 100);
        $display("errors: data %0d ack %0d timeout %0d", err_data, err_ack, err_timeout + 1);
        $display("FAIL: see errors above");
        $finish;
    end

    //************************************************************************
    // main sequence
    //************************************************************************
    initial begin
        cs_n   = 1'b1;
        cmd    = 1'b0;
        addr   = '0;
        datain = '0;
        rst_n  = 1'b0;
        for (int b = 0; b < 3; b++) begin
            for (int i = 0; i < 32; i++) begin
                model[b][i] = '0;
            end
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset_state();
        test_write_read();
        test_id_word();
        test_range_unmapped();
        test_isolation();
        test_slow_release();
        $display("errors: data %0d ack %0d timeout %0d", err_data, err_ack, err_timeout);
        if (err_data == 0 && err_ack == 0 && err_timeout == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== um_cfg.f ====
+incdir+include
logic/lb_pkg.sv
logic/regmap_pkg.sv
logic/cfg_dispatch.sv
logic/cfg_reg_bank.sv
logic/um_cfg_top.sv
sim/tb_um_cfg.sv

// ==== Makefile ====
# Verilator build and run of the config side testbench

SRCS := um_cfg.f $(wildcard logic/*.sv) $(wildcard sim/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_um_cfg: $(SRCS)
	verilator --binary --timing -j 0 -f um_cfg.f --top-module tb_um_cfg -o Vtb_um_cfg

# pass or fail from the log, not from the binary's exit status
run: obj_dir/Vtb_um_cfg
	./obj_dir/Vtb_um_cfg | tee sim.log
	grep -qx "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
